//--- filelist.f
verilog/pic_isa_pkg.sv
verilog/pic_sfr_pkg.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/file_op_unit.sv
verilog/flow_ctrl.sv
verilog/sfr_top.sv
tb/sfr_props.sv
tb/sfr_tb.sv

//--- tb/sfr_props.sv
module sfr_props
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input logic        clock,
	input logic        reset,
	input logic        en,
	input flow_t       flow,
	input pc_t         pc_target,
	input file_write_t result,
	input file_addr_t  eff_addr,
	input byte_t       pclath
);

	timeunit 1ns;
	timeprecision 100ps;

	int         fail_count = 0; // watched by the testbench
	logic [3:0] strobes;

	assign strobes = flow;

	property strobes_exclusive;
		@(posedge clock) disable iff (reset)
		$onehot0(strobes);
	endproperty

	// strobes last only one cycle
	property strobes_drop;
		@(posedge clock) disable iff (reset)
		!en |=> (strobes == 4'b0000);
	endproperty

	// computed goto puts the pclath low bits above the new pcl
	property pcl_goto_target;
		@(posedge clock) disable iff (reset)
		(en && result.write && eff_addr == PCL_ADDR)
		|=> (flow.goto && pc_target == pc_t'({$past(pclath[PCLATH_BITS-1:0]),
			$past(result.data)}));
	endproperty

	a_strobes_exclusive: assert property (strobes_exclusive)
	else
	begin
		$error("more than one flow strobe is high");
		fail_count++;
	end

	a_strobes_drop: assert property (strobes_drop)
	else
	begin
		$error("flow strobe high after a cycle without en");
		fail_count++;
	end

	a_pcl_goto_target: assert property (pcl_goto_target)
	else
	begin
		$error("pcl write did not give the computed goto target");
		fail_count++;
	end

endmodule

bind sfr_top sfr_props sfr_props_inst (
	.clock     (clock),
	.reset     (reset),
	.en        (en),
	.flow      (flow),
	.pc_target (pc_target),
	.result    (result),
	.eff_addr  (eff_addr),
	.pclath    (pclath)
);

//--- tb/sfr_tb.sv
module sfr_tb
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	localparam int ROUNDS       = 4; // random values per data test
	// every do_instr call takes two clock cycles
	localparam int INSTR_COUNT  = (ROUNDS * 5 + 1) + (1 + 8 * 6) + (ROUNDS * 6 * 3 + 5) + 8;
	localparam int TEST_CYCLES  = RESET_CYCLES + 2 * INSTR_COUNT + 10;

	logic                   clock;
	logic                   reset;
	logic                   en;
	logic [4:0]             opcode;
	logic [9:0]             operand;
	logic                   write_en;
	byte_t                  alu_in;
	logic                   z_en;
	logic                   z;
	flow_t                  flow;
	pc_t                    pc_target;
	byte_t                  file_data;
	logic [PORTA_WIDTH-1:0] port_a;
	byte_t                  port_b;
	byte_t                  status;
	int                     seed = 21;

	sfr_top sfr_top_inst (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.opcode    (opcode),
		.operand   (operand),
		.write_en  (write_en),
		.alu_in    (alu_in),
		.z_en      (z_en),
		.z         (z),
		.flow      (flow),
		.pc_target (pc_target),
		.file_data (file_data),
		.port_a    (port_a),
		.port_b    (port_b),
		.status    (status)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			fail_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
				test_name, expected, actual));
	endtask

	// one enabled cycle then en drops
	task automatic do_instr(input opcode_e op, input logic [9:0] opnd, input byte_t w,
		input logic wen);
		@(negedge clock);
		opcode   = op;
		operand  = opnd;
		alu_in   = w;
		write_en = wen;
		en       = 1'b1;
		@(negedge clock);
		en = 1'b0; // results are settled here
	endtask

	function automatic logic [9:0] make_operand(input logic [2:0] upper, input file_addr_t a);
		return {upper, a};
	endfunction

	function automatic logic [3:0] flow_bits(input logic g, input logic c, input logic r,
		input logic s);
		return {g, c, r, s}; // goto call ret skip
	endfunction

	function automatic byte_t expect_unary(input opcode_e op, input byte_t v);
		case (op)
			OP_DECF:  return v - 8'd1;
			OP_INCF:  return v + 8'd1;
			OP_COMF:  return 8'hFF ^ v;
			OP_RRF:   return (v >> 1) | (v << 7);
			OP_RLF:   return (v << 1) | (v >> 7);
			OP_SWAPF: return (v << 4) | (v >> 4);
			default:  return v;
		endcase
	endfunction

	// rotates and swap keep Z
	function automatic logic changes_z(input opcode_e op);
		return !(op == OP_RRF || op == OP_RLF || op == OP_SWAPF);
	endfunction

	task automatic test_reset();
		check_value("test_reset status", STATUS_RESET, status);
		check_value("test_reset port_a", 0, port_a);
		check_value("test_reset port_b", 0, port_b);
		check_value("test_reset pc_target", 0, pc_target);
		check_value("test_reset flow", 0, flow);
	endtask

	task automatic test_move_indirect();
		byte_t      va;
		byte_t      vb;
		byte_t      vc;
		file_addr_t tgt;
		for (int r = 0; r < ROUNDS; r++)
		begin
			va  = $random(seed);
			vb  = $random(seed);
			vc  = $random(seed);
			tgt = 7'd12 + 7'({$random(seed)} % 68); // general purpose bytes
			do_instr(OP_MOVWF, make_operand(3'd0, PORTA_ADDR), va, 1'b0);
			check_value("test_move_indirect port_a", va[PORTA_WIDTH-1:0], port_a);
			do_instr(OP_MOVWF, make_operand(3'd0, PORTB_ADDR), vb, 1'b0);
			check_value("test_move_indirect port_b", vb, port_b);
			do_instr(OP_MOVWF, make_operand(3'd0, FSR_ADDR), {1'b0, tgt}, 1'b0);
			do_instr(OP_MOVWF, make_operand(3'd0, INDF_ADDR), vc, 1'b0);
			do_instr(OP_IORWF, make_operand(3'd0, tgt), 8'h00, 1'b0); // read only
			check_value("test_move_indirect readback", vc, file_data);
		end
		do_instr(OP_IORWF, make_operand(3'd0, 7'd100), 8'h00, 1'b0);
		check_value("test_move_indirect out of range", 0, file_data);
	endtask

	task automatic run_bit_test(input opcode_e op, input int b, input byte_t v);
		logic exp_skip;
		exp_skip = (op == OP_BTFSS) ? v[b] : !v[b];
		do_instr(op, make_operand(3'(b), PORTB_ADDR), 8'h00, 1'b0);
		check_value($sformatf("test_bits %s bit %0d", op.name(), b),
			flow_bits(1'b0, 1'b0, 1'b0, exp_skip), flow);
	endtask

	task automatic test_bits();
		byte_t exp_b;
		exp_b = $random(seed);
		do_instr(OP_MOVWF, make_operand(3'd0, PORTB_ADDR), exp_b, 1'b0);
		for (int b = 0; b < 8; b++)
		begin
			do_instr(OP_BSF, make_operand(3'(b), PORTB_ADDR), 8'h00, 1'b0);
			exp_b[b] = 1'b1;
			check_value("test_bits bsf", exp_b, port_b);
			run_bit_test(OP_BTFSS, b, exp_b);
			run_bit_test(OP_BTFSC, b, exp_b);
			do_instr(OP_BCF, make_operand(3'(b), PORTB_ADDR), 8'h00, 1'b0);
			exp_b[b] = 1'b0;
			check_value("test_bits bcf", exp_b, port_b);
			run_bit_test(OP_BTFSC, b, exp_b);
			run_bit_test(OP_BTFSS, b, exp_b);
		end
	endtask

	task automatic test_unary();
		opcode_e ops [6] = '{OP_DECF, OP_INCF, OP_COMF, OP_RRF, OP_RLF, OP_SWAPF};
		byte_t   v;
		byte_t   exp_r;
		logic    exp_z;
		exp_z = STATUS_RESET[Z_BIT];
		for (int r = 0; r < ROUNDS; r++)
		begin
			// first two values reach zero on decf, incf and comf
			v = (r == 0) ? 8'h01 : (r == 1) ? 8'hFF : byte_t'($random(seed));
			for (int k = 0; k < 6; k++)
			begin
				exp_r = expect_unary(ops[k], v);
				if (changes_z(ops[k]))
					exp_z = (exp_r == 8'h00);
				do_instr(OP_MOVWF, make_operand(3'd0, PORTB_ADDR), v, 1'b0);
				do_instr(ops[k], make_operand(3'd0, PORTB_ADDR), 8'h00, 1'b0);
				check_value($sformatf("test_unary %s to w", ops[k].name()), exp_r, file_data);
				check_value("test_unary file kept", v, port_b);
				check_value("test_unary z to w", exp_z, status[Z_BIT]);
				do_instr(ops[k], make_operand(3'd1, PORTB_ADDR), 8'h00, 1'b0);
				check_value($sformatf("test_unary %s to file", ops[k].name()), exp_r, port_b);
				check_value("test_unary z to file", exp_z, status[Z_BIT]);
			end
		end
		do_instr(OP_MOVWF, make_operand(3'd0, PORTB_ADDR), 8'h01, 1'b0);
		do_instr(OP_DECFSZ, make_operand(3'd1, PORTB_ADDR), 8'h00, 1'b0);
		check_value("test_unary decfsz skip", flow_bits(1'b0, 1'b0, 1'b0, 1'b1), flow);
		check_value("test_unary decfsz z", 1, status[Z_BIT]);
		check_value("test_unary decfsz file", 0, port_b);
		do_instr(OP_MOVWF, make_operand(3'd0, PORTB_ADDR), 8'h05, 1'b0);
		do_instr(OP_DECF, make_operand(3'd0, PORTB_ADDR), 8'h00, 1'b0); // clears Z
		check_value("test_unary z before clrf", 0, status[Z_BIT]);
		do_instr(OP_CLRF, make_operand(3'd0, PORTB_ADDR), 8'h00, 1'b0);
		check_value("test_unary clrf file", 0, port_b);
		check_value("test_unary clrf z", 1, status[Z_BIT]);
	endtask

	task automatic test_flow();
		pc_t   tgt;
		byte_t v;
		tgt = $random(seed);
		do_instr(OP_GOTO, tgt, 8'h00, 1'b0);
		check_value("test_flow goto", flow_bits(1'b1, 1'b0, 1'b0, 1'b0), flow);
		check_value("test_flow goto target", tgt, pc_target);
		tgt = $random(seed);
		do_instr(OP_CALL, tgt, 8'h00, 1'b0);
		check_value("test_flow call", flow_bits(1'b0, 1'b1, 1'b0, 1'b0), flow);
		check_value("test_flow call target", tgt, pc_target);
		@(negedge clock); // one edge with en low
		check_value("test_flow strobe drop", 0, flow);
		do_instr(OP_MOVWF, make_operand(3'd0, PCLATH_ADDR), 8'd3, 1'b0);
		check_value("test_flow pclath write", 0, flow);
		v = $random(seed);
		do_instr(OP_MOVWF, make_operand(3'd0, PCL_ADDR), v, 1'b0);
		check_value("test_flow computed goto", flow_bits(1'b1, 1'b0, 1'b0, 1'b0), flow);
		check_value("test_flow computed target", 3 * 256 + v, pc_target);
		do_instr(OP_RETURN, 10'd0, 8'h00, 1'b0);
		check_value("test_flow return", flow_bits(1'b0, 1'b0, 1'b1, 1'b0), flow);
		do_instr(OP_RETLW, 10'd0, 8'h00, 1'b0);
		check_value("test_flow retlw", flow_bits(1'b0, 1'b0, 1'b1, 1'b0), flow);
		do_instr(OP_RETFIE, 10'd0, 8'h00, 1'b0);
		check_value("test_flow retfie", flow_bits(1'b0, 1'b0, 1'b1, 1'b0), flow);
		do_instr(OP_IORWF, make_operand(3'd0, INTCON_ADDR), 8'h00, 1'b0);
		check_value("test_flow gie", 1, file_data[GIE_BIT]);
	endtask

	task automatic test_z_path();
		@(negedge clock);
		z_en = 1'b1;
		z    = 1'b0; // clrf left Z set
		@(negedge clock);
		check_value("test_z_path clear", {STATUS_RESET[7:3], 1'b0, STATUS_RESET[1:0]}, status);
		z = 1'b1;
		@(negedge clock);
		check_value("test_z_path set", {STATUS_RESET[7:3], 1'b1, STATUS_RESET[1:0]}, status);
		z_en = 1'b0;
	endtask

	// bound assertions count their failures
	always @(negedge clock)
	begin
		if (sfr_top_inst.sfr_props_inst.fail_count != 0)
			fail_run("an assertion on the DUT failed");
	end

	initial
	begin
		#(TEST_CYCLES * 2 * CLK_PERIOD);
		fail_run("timeout, the tests did not finish in time");
	end

	initial
	begin
		clock    = 1'b0;
		reset    = 1'b1;
		en       = 1'b0;
		opcode   = '0;
		operand  = '0;
		write_en = 1'b0;
		alu_in   = '0;
		z_en     = 1'b0;
		z        = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_reset();
		test_move_indirect();
		test_bits();
		test_unary();
		test_flow();
		test_z_path();
		@(negedge clock);
		if (sfr_top_inst.sfr_props_inst.fail_count != 0)
			fail_run("an assertion on the DUT failed");
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- verilog/file_op_unit.sv
module file_op_unit
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input  decoded_t    decoded,
	input  byte_t       rd_data,
	input  byte_t       alu_in,
	input  logic        write_en,
	output file_write_t result
);

	byte_t unary_val;
	logic  unary_zero;
	logic  rot_or_swap; // these leave Z alone
	byte_t bit_mask;

	assign bit_mask = 8'd1 << decoded.bit_sel;

	always_comb
	begin
		rot_or_swap = 1'b0;
		case (decoded.unary_op)
			OP_DECF, OP_DECFSZ: unary_val = rd_data - 8'd1;
			OP_INCF, OP_INCFSZ: unary_val = rd_data + 8'd1;
			OP_COMF:            unary_val = ~rd_data;
			OP_RRF:
			begin
				unary_val   = {rd_data[0], rd_data[7:1]}; // no carry in
				rot_or_swap = 1'b1;
			end
			OP_RLF:
			begin
				unary_val   = {rd_data[6:0], rd_data[7]};
				rot_or_swap = 1'b1;
			end
			OP_SWAPF:
			begin
				unary_val   = {rd_data[3:0], rd_data[7:4]};
				rot_or_swap = 1'b1;
			end
			default:            unary_val = rd_data; // movf
		endcase
	end

	assign unary_zero = (unary_val == 8'd0);

	always_comb
	begin
		result      = '0;
		result.data = rd_data;
		case (decoded.kind)
			K_BIT_CLEAR:
			begin
				result.data  = rd_data & ~bit_mask;
				result.write = 1'b1;
			end
			K_BIT_SET:
			begin
				result.data  = rd_data | bit_mask;
				result.write = 1'b1;
			end
			K_BIT_TEST_CLEAR: result.skip = ~rd_data[decoded.bit_sel];
			K_BIT_TEST_SET:   result.skip = rd_data[decoded.bit_sel];
			K_ALU_BYTE:
			begin
				// write_en low means the upstream only wants the read
				result.data  = write_en ? alu_in : rd_data;
				result.write = write_en;
			end
			K_UNARY:
			begin
				result.data    = unary_val;
				result.write   = decoded.dest_file;
				result.z_write = ~rot_or_swap;
				result.z_value = unary_zero;
			end
			K_SKIP_UNARY:
			begin
				result.data    = unary_val;
				result.write   = decoded.dest_file;
				result.z_write = 1'b1;
				result.z_value = unary_zero;
				result.skip    = unary_zero;
			end
			K_CLEAR:
			begin
				result.data    = '0;
				result.write   = 1'b1;
				result.z_write = 1'b1;
				result.z_value = 1'b1;
			end
			K_MOVE_W:
			begin
				result.data  = alu_in;
				result.write = 1'b1;
			end
			K_RETURN_INT: result.gie_set = 1'b1;
			default:      result.skip    = 1'b0;
		endcase
	end

endmodule

//--- verilog/flow_ctrl.sv
module flow_ctrl
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        en,
	input  decoded_t    decoded,
	input  file_write_t result,
	input  byte_t       rd_data,
	input  file_addr_t  eff_addr,
	input  byte_t       pclath,
	output flow_t       flow,
	output pc_t         pc_target,
	output byte_t       file_data
);

	logic  is_jump;
	logic  pcl_write; // computed goto
	logic  show_result;
	logic  show_read;
	flow_t flow_next;

	assign is_jump     = (decoded.kind == K_JUMP);
	assign pcl_write   = result.write && (eff_addr == PCL_ADDR);
	assign show_result = (decoded.kind == K_UNARY || decoded.kind == K_SKIP_UNARY)
		&& !decoded.dest_file;
	assign show_read   = (decoded.kind == K_ALU_BYTE) && !result.write;

	always_comb
	begin
		flow_next.goto = (is_jump && !decoded.call) || pcl_write;
		flow_next.call = is_jump && decoded.call;
		flow_next.ret  = (decoded.kind == K_RETURN) || (decoded.kind == K_RETURN_INT);
		flow_next.skip = result.skip && !pcl_write; // goto already moves the pc
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			flow      <= '0;
			pc_target <= '0;
			file_data <= '0;
		end
		else if (en)
		begin
			flow <= flow_next;
			if (is_jump)
				pc_target <= decoded.target;
			else if (pcl_write)
				pc_target <= pc_t'({pclath[PCLATH_BITS-1:0], result.data});
			if (show_result)
				file_data <= result.data;
			else if (show_read)
				file_data <= rd_data;
		end
		else
		begin
			flow <= '0; // strobes last one cycle
		end
	end

endmodule

//--- verilog/instr_decode.sv
module instr_decode
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input  opcode_e    opcode,
	input  logic [9:0] operand,
	output decoded_t   decoded
);

	always_comb
	begin
		decoded           = '0;
		decoded.kind      = K_NONE;
		decoded.unary_op  = opcode;
		decoded.bit_sel   = operand[9:7];
		decoded.dest_file = operand[7];
		decoded.addr      = operand[6:0];
		decoded.indirect  = (operand[6:0] == INDF_ADDR);

		case (opcode)
			OP_CALL, OP_GOTO:
			begin
				decoded.kind   = K_JUMP;
				decoded.call   = (opcode == OP_CALL);
				decoded.target = operand; // full operand is the jump address
			end
			OP_BCF:    decoded.kind = K_BIT_CLEAR;
			OP_BSF:    decoded.kind = K_BIT_SET;
			OP_BTFSC:  decoded.kind = K_BIT_TEST_CLEAR;
			OP_BTFSS:  decoded.kind = K_BIT_TEST_SET;
			OP_SUBWF, OP_IORWF, OP_ANDWF, OP_XORWF, OP_ADDWF:
				decoded.kind = K_ALU_BYTE; // result computed upstream
			OP_DECF, OP_INCF, OP_COMF, OP_MOVF, OP_RRF, OP_RLF, OP_SWAPF:
				decoded.kind = K_UNARY;
			OP_DECFSZ, OP_INCFSZ:
				decoded.kind = K_SKIP_UNARY;
			OP_CLRF:   decoded.kind = K_CLEAR;
			OP_MOVWF:  decoded.kind = K_MOVE_W;
			OP_RETURN, OP_RETLW:
				decoded.kind = K_RETURN;
			OP_RETFIE: decoded.kind = K_RETURN_INT;
			default:   decoded.kind = K_NONE;
		endcase
	end

endmodule

//--- verilog/pic_isa_pkg.sv
package pic_isa_pkg;

	typedef logic [7:0] byte_t;      // data word
	typedef logic [9:0] pc_t;        // program address
	typedef logic [6:0] file_addr_t; // file register address
	typedef logic [2:0] bit_sel_t;   // bit index inside a byte

	// opcodes handled by this block, anything else is a no-op here
	typedef enum logic [4:0] {
		OP_CALL   = 5'd1,
		OP_GOTO   = 5'd2,
		OP_BCF    = 5'd3,
		OP_BSF    = 5'd4,
		OP_BTFSC  = 5'd5,
		OP_BTFSS  = 5'd6,
		OP_RETFIE = 5'd7, // moved into the 5 bit space
		OP_RETLW  = 5'd8,
		OP_SUBWF  = 5'd11,
		OP_DECF   = 5'd12,
		OP_IORWF  = 5'd13,
		OP_ANDWF  = 5'd14,
		OP_XORWF  = 5'd15,
		OP_ADDWF  = 5'd16,
		OP_MOVF   = 5'd17,
		OP_COMF   = 5'd18,
		OP_INCF   = 5'd19,
		OP_DECFSZ = 5'd20,
		OP_RRF    = 5'd21,
		OP_RLF    = 5'd22,
		OP_SWAPF  = 5'd23,
		OP_INCFSZ = 5'd24,
		OP_CLRF   = 5'd28,
		OP_MOVWF  = 5'd30,
		OP_RETURN = 5'd31
	} opcode_e;

	typedef enum logic [3:0] {
		K_NONE,
		K_JUMP,
		K_BIT_CLEAR,
		K_BIT_SET,
		K_BIT_TEST_CLEAR,
		K_BIT_TEST_SET,
		K_ALU_BYTE,
		K_UNARY,
		K_SKIP_UNARY,
		K_CLEAR,
		K_MOVE_W,
		K_RETURN,
		K_RETURN_INT
	} op_kind_e;

	typedef struct packed {
		op_kind_e   kind;
		opcode_e    unary_op;  // picks the unary result
		bit_sel_t   bit_sel;
		logic       dest_file; // operand bit 7, 1 = back to file
		file_addr_t addr;
		logic       indirect;  // addr was INDF
		logic       call;
		pc_t        target;
	} decoded_t;

endpackage

//--- verilog/pic_sfr_pkg.sv
package pic_sfr_pkg;

	// special register map, single bank
	localparam pic_isa_pkg::file_addr_t INDF_ADDR   = 7'd0;
	localparam pic_isa_pkg::file_addr_t PCL_ADDR    = 7'd2;
	localparam pic_isa_pkg::file_addr_t STATUS_ADDR = 7'd3;
	localparam pic_isa_pkg::file_addr_t FSR_ADDR    = 7'd4;
	localparam pic_isa_pkg::file_addr_t PORTA_ADDR  = 7'd5;
	localparam pic_isa_pkg::file_addr_t PORTB_ADDR  = 7'd6;
	localparam pic_isa_pkg::file_addr_t PCLATH_ADDR = 7'd10;
	localparam pic_isa_pkg::file_addr_t INTCON_ADDR = 7'd11;

	localparam int FILE_DEPTH = 80;

	localparam pic_isa_pkg::byte_t STATUS_RESET = 8'd24;
	localparam int Z_BIT   = 2; // STATUS zero flag
	localparam int GIE_BIT = 7; // INTCON global interrupt enable

	localparam int PCLATH_BITS = 2; // pclath bits above pcl in a computed goto
	localparam int PORTA_WIDTH = 5;

	// what one instruction does to the file
	typedef struct packed {
		logic                write;
		pic_isa_pkg::byte_t  data;
		logic                z_write;
		logic                z_value;
		logic                gie_set;
		logic                skip;
	} file_write_t;

	typedef struct packed {
		logic goto;
		logic call;
		logic ret;
		logic skip;
	} flow_t;

endpackage

//--- verilog/reg_file.sv
module reg_file
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  file_addr_t             addr,
	input  logic                   indirect,
	input  file_write_t            wr,
	input  logic                   z_en,
	input  logic                   z,
	input  logic                   en,
	output byte_t                  rd_data,
	output file_addr_t             eff_addr,
	output byte_t                  pclath,
	output logic [PORTA_WIDTH-1:0] port_a,
	output byte_t                  port_b,
	output byte_t                  status
);

	byte_t mem [FILE_DEPTH];
	logic  in_range;

	// indirect access uses the low 7 bits of FSR
	assign eff_addr = indirect ? mem[FSR_ADDR][6:0] : addr;
	assign in_range = (eff_addr < FILE_DEPTH);

	// unimplemented space reads as zero
	assign rd_data = in_range ? mem[eff_addr] : '0;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < FILE_DEPTH; i++)
			begin
				mem[i] <= '0;
			end
			mem[STATUS_ADDR] <= STATUS_RESET;
		end
		else if (en)
		begin
			if (wr.write && in_range)
				mem[eff_addr] <= wr.data;
			// flag update wins over a byte write to STATUS
			if (wr.z_write)
				mem[STATUS_ADDR][Z_BIT] <= wr.z_value;
			if (wr.gie_set)
				mem[INTCON_ADDR][GIE_BIT] <= 1'b1; // retfie
		end
		else if (z_en)
		begin
			mem[STATUS_ADDR][Z_BIT] <= z; // zero flag from the upstream ALU
		end
	end

	assign pclath = mem[PCLATH_ADDR];
	assign port_a = mem[PORTA_ADDR][PORTA_WIDTH-1:0];
	assign port_b = mem[PORTB_ADDR];
	assign status = mem[STATUS_ADDR];

endmodule

//--- verilog/sfr_top.sv
module sfr_top
	import pic_isa_pkg::*;
	import pic_sfr_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   en,
	input  logic [4:0]             opcode,
	input  logic [9:0]             operand,
	input  logic                   write_en,
	input  byte_t                  alu_in,
	input  logic                   z_en,
	input  logic                   z,
	output flow_t                  flow,
	output pc_t                    pc_target,
	output byte_t                  file_data,
	output logic [PORTA_WIDTH-1:0] port_a,
	output byte_t                  port_b,
	output byte_t                  status
);

	decoded_t    decoded;
	file_write_t result;
	byte_t       rd_data;
	byte_t       pclath;
	file_addr_t  eff_addr;

	instr_decode instr_decode_inst (
		.opcode  (opcode_e'(opcode)),
		.operand (operand),
		.decoded (decoded)
	);

	reg_file reg_file_inst (
		.clock    (clock),
		.reset    (reset),
		.addr     (decoded.addr),
		.indirect (decoded.indirect),
		.wr       (result),
		.z_en     (z_en),
		.z        (z),
		.en       (en),
		.rd_data  (rd_data),
		.eff_addr (eff_addr),
		.pclath   (pclath),
		.port_a   (port_a),
		.port_b   (port_b),
		.status   (status)
	);

	file_op_unit file_op_unit_inst (
		.decoded  (decoded),
		.rd_data  (rd_data),
		.alu_in   (alu_in),
		.write_en (write_en),
		.result   (result)
	);

	flow_ctrl flow_ctrl_inst (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.decoded   (decoded),
		.result    (result),
		.rd_data   (rd_data),
		.eff_addr  (eff_addr),
		.pclath    (pclath),
		.flow      (flow),
		.pc_target (pc_target),
		.file_data (file_data)
	);

endmodule
